/* verilog/exu_config.svh */
////////////////////////////////////////
// Widths, lane count and encodings for the execution stage
////////////////////////////////////////
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

`define EXU_XLEN      32
`define EXU_RFIDX_W   4
`define EXU_RF_NUM    16                    // Upper index bit of rd/rs1/rs2 is dropped
`define EXU_LANES     2                     // Power of two only
`define EXU_LANE_W    ($clog2(`EXU_LANES))

// ALU operation codes
`define EXU_OP_W      3
`define EXU_OP_ADD    3'd0
`define EXU_OP_SUB    3'd1
`define EXU_OP_AND    3'd2
`define EXU_OP_OR     3'd3
`define EXU_OP_XOR    3'd4

`define EXU_OPC_OP    7'b0110011
`define EXU_OPC_OPIMM 7'b0010011

`endif

/* verilog/exu_pkg.sv */
////////////////////////////////////////
// Instruction word type with R and I views
////////////////////////////////////////
`default_nettype none

package exu_pkg;

  // One 32-bit word, decoded both ways by dispatch
  typedef union packed {
    // Register-register form
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;

    // Register-immediate form
    struct packed {
      logic [11:0] imm12;   // Sign bit at [11]
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } exu_instr_u;

endpackage

`default_nettype wire

/* verilog/exu_lane_if.sv */
////////////////////////////////////////
// Dispatch to lane to write-back link
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

interface exu_lane_if;

  // Issue side
  logic                    iss_valid;
  logic                    iss_ready;
  logic [`EXU_OP_W-1:0]    iss_op;
  logic [`EXU_RFIDX_W-1:0] iss_rdidx;
  logic [`EXU_XLEN-1:0]    iss_a;
  logic [`EXU_XLEN-1:0]    iss_b;

  // Result side
  logic                    res_valid;
  logic                    res_ready;
  logic [`EXU_RFIDX_W-1:0] res_rdidx;
  logic [`EXU_XLEN-1:0]    res_data;

  modport disp (output iss_valid, iss_op, iss_rdidx, iss_a, iss_b, input iss_ready);

  modport lane (
    input  iss_valid, iss_op, iss_rdidx, iss_a, iss_b, res_ready,
    output iss_ready, res_valid, res_rdidx, res_data
  );

  modport wbck (input res_valid, res_rdidx, res_data, output res_ready);

endinterface

`default_nettype wire

/* verilog/exu_regfile.sv */
////////////////////////////////////////
// Integer register file, 2 read / 1 write
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module exu_regfile (
  input  logic                    clk,
  input  logic                    i_reset,
  input  logic [`EXU_RFIDX_W-1:0] i_rs1idx,
  input  logic [`EXU_RFIDX_W-1:0] i_rs2idx,
  input  logic                    i_wen,
  input  logic [`EXU_RFIDX_W-1:0] i_wrdidx,
  input  logic [`EXU_XLEN-1:0]    i_wdata,
  output logic [`EXU_XLEN-1:0]    o_rs1_data,
  output logic [`EXU_XLEN-1:0]    o_rs2_data
);

  logic [`EXU_XLEN-1:0] rf_q [`EXU_RF_NUM];

  for (genvar r = 0; r < `EXU_RF_NUM; r++) begin : g_reg
    if (r == 0) begin : g_x0
      assign rf_q[r] = '0;                // x0 hardwired
    end else begin : g_xn
      always_ff @(posedge clk) begin
        if (i_reset) begin
          rf_q[r] <= '0;
        end else if (i_wen && (i_wrdidx == r)) begin
          rf_q[r] <= i_wdata;
        end
      end
    end
  end

  // Read ports are combinational
  assign o_rs1_data = rf_q[i_rs1idx];
  assign o_rs2_data = rf_q[i_rs2idx];

endmodule

`default_nettype wire

/* verilog/exu_dispatch.sv */
////////////////////////////////////////
// Decode, scoreboard stall and
// round-robin issue to the ALU lanes
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module exu_dispatch
  import exu_pkg::*;
(
  input  logic                    clk,
  input  logic                    i_reset,
  input  logic                    i_valid,
  input  exu_instr_u              i_instr,
  input  logic [`EXU_XLEN-1:0]    i_rs1_data,
  input  logic [`EXU_XLEN-1:0]    i_rs2_data,
  input  logic                    i_ret_valid,
  input  logic [`EXU_RFIDX_W-1:0] i_ret_rdidx,
  output logic                    o_ready,
  output logic [`EXU_RFIDX_W-1:0] o_rs1idx,
  output logic [`EXU_RFIDX_W-1:0] o_rs2idx,
  exu_lane_if.disp                lanes [`EXU_LANES]
);

  logic                    is_op;
  logic                    is_opimm;
  logic                    f7_ok;
  logic                    alt_sub;
  logic                    dec_f3_ok;
  logic                    dec_ok;
  logic [`EXU_OP_W-1:0]    dec_op;
  logic [`EXU_XLEN-1:0]    imm_sext;
  logic [`EXU_RFIDX_W-1:0] rs1idx;
  logic [`EXU_RFIDX_W-1:0] rs2idx;
  logic [`EXU_RFIDX_W-1:0] rdidx;
  logic [`EXU_RF_NUM-1:0]  busy_q;
  logic [`EXU_RF_NUM-1:0]  busy_nxt;
  logic                    hazard;
  logic                    issue_req;
  logic                    issue_fire;
  logic [`EXU_LANES-1:0]   lane_ready;
  logic [`EXU_LANE_W-1:0]  lane_ptr;

  ////////////////////////////////////////
  // Decode
  assign is_op    = (i_instr.r.opcode == `EXU_OPC_OP);
  assign is_opimm = (i_instr.i.opcode == `EXU_OPC_OPIMM);
  assign alt_sub  = is_op & (i_instr.r.funct7 == 7'b0100000);
  assign f7_ok    = (i_instr.r.funct7 == 7'b0000000) | (alt_sub & (i_instr.r.funct3 == 3'b000));

  always_comb begin
    dec_f3_ok = 1'b1;
    case (i_instr.i.funct3)
      3'b000:  dec_op = alt_sub ? `EXU_OP_SUB : `EXU_OP_ADD;
      3'b100:  dec_op = `EXU_OP_XOR;
      3'b110:  dec_op = `EXU_OP_OR;
      3'b111:  dec_op = `EXU_OP_AND;
      default: begin
        dec_op    = `EXU_OP_ADD;
        dec_f3_ok = 1'b0;
      end
    endcase
  end

  assign dec_ok   = dec_f3_ok & (is_opimm | (is_op & f7_ok));
  assign imm_sext = {{(`EXU_XLEN-12){i_instr.i.imm12[11]}}, i_instr.i.imm12};

  assign rs1idx   = i_instr.i.rs1[`EXU_RFIDX_W-1:0];
  assign rs2idx   = i_instr.r.rs2[`EXU_RFIDX_W-1:0];
  assign rdidx    = i_instr.r.rd[`EXU_RFIDX_W-1:0];
  assign o_rs1idx = rs1idx;
  assign o_rs2idx = rs2idx;

  ////////////////////////////////////////
  // Scoreboard
  // rd is checked too, so a pending write is never overtaken
  assign hazard = busy_q[rs1idx] | (is_op & busy_q[rs2idx]) | busy_q[rdidx];

  assign issue_req  = i_valid & dec_ok & (rdidx != '0) & ~hazard;
  assign issue_fire = issue_req & lane_ready[lane_ptr];
  assign o_ready    = lane_ready[lane_ptr] & ~hazard;   // Discarded words pass here too

  always_comb begin
    busy_nxt = busy_q;
    if (i_ret_valid) begin
      busy_nxt[i_ret_rdidx] = 1'b0;
    end
    if (issue_fire) begin
      busy_nxt[rdidx] = 1'b1;   // Issue wins over retire
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      busy_q   <= '0;
      lane_ptr <= '0;
    end else begin
      busy_q <= busy_nxt;
      if (issue_fire) begin
        lane_ptr <= lane_ptr + 1'b1;   // Wraps, lane count is 2^n
      end
    end
  end

  // Payload goes to every lane, valid only to the pointed one
  for (genvar g = 0; g < `EXU_LANES; g++) begin : g_lane
    assign lane_ready[g]      = lanes[g].iss_ready;
    assign lanes[g].iss_valid = issue_req & (lane_ptr == g);
    assign lanes[g].iss_op    = dec_op;
    assign lanes[g].iss_rdidx = rdidx;
    assign lanes[g].iss_a     = i_rs1_data;
    assign lanes[g].iss_b     = is_opimm ? imm_sext : i_rs2_data;
  end

endmodule

`default_nettype wire

/* verilog/exu_lane.sv */
////////////////////////////////////////
// Two-stage ALU lane with per-stage valid
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module exu_lane (
  input  logic     clk,
  input  logic     i_reset,
  exu_lane_if.lane port
);

  logic                    s1_valid;
  logic [`EXU_OP_W-1:0]    s1_op;
  logic [`EXU_RFIDX_W-1:0] s1_rdidx;
  logic [`EXU_XLEN-1:0]    s1_a;
  logic [`EXU_XLEN-1:0]    s1_b;
  logic                    s2_valid;
  logic [`EXU_RFIDX_W-1:0] s2_rdidx;
  logic [`EXU_XLEN-1:0]    s2_data;
  logic                    s1_ready;
  logic                    s2_ready;
  logic                    iss_fire;
  logic                    s1_fire;
  logic [`EXU_XLEN-1:0]    alu_res;

  // Ready ripples back from the result port
  assign s2_ready = ~s2_valid | port.res_ready;
  assign s1_ready = ~s1_valid | s2_ready;
  assign iss_fire = port.iss_valid & s1_ready;
  assign s1_fire  = s1_valid & s2_ready;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= iss_fire | (s1_valid & ~s2_ready);
      s2_valid <= s1_fire | (s2_valid & ~port.res_ready);
    end
  end

  ////////////////////////////////////////
  // Stage 1 operand capture
  always_ff @(posedge clk) begin
    if (iss_fire) begin
      s1_op    <= port.iss_op;
      s1_rdidx <= port.iss_rdidx;
      s1_a     <= port.iss_a;
      s1_b     <= port.iss_b;
    end
  end

  always_comb begin
    case (s1_op)
      `EXU_OP_SUB: alu_res = s1_a - s1_b;
      `EXU_OP_AND: alu_res = s1_a & s1_b;
      `EXU_OP_OR:  alu_res = s1_a | s1_b;
      `EXU_OP_XOR: alu_res = s1_a ^ s1_b;
      default:     alu_res = s1_a + s1_b;   // ADD and ADDI
    endcase
  end

  // Stage 2 result register
  always_ff @(posedge clk) begin
    if (s1_fire) begin
      s2_rdidx <= s1_rdidx;
      s2_data  <= alu_res;
    end
  end

  assign port.iss_ready = s1_ready;
  assign port.res_valid = s2_valid;
  assign port.res_rdidx = s2_rdidx;
  assign port.res_data  = s2_data;

endmodule

`default_nettype wire

/* verilog/exu_wbck.sv */
////////////////////////////////////////
// In-order write-back from the lanes
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module exu_wbck (
  input  logic                    clk,
  input  logic                    i_reset,
  input  logic                    i_wb_ready,
  exu_lane_if.wbck                lanes [`EXU_LANES],
  output logic                    o_wb_valid,
  output logic [`EXU_RFIDX_W-1:0] o_wb_rdidx,
  output logic [`EXU_XLEN-1:0]    o_wb_data,
  output logic                    o_rf_wen,
  output logic [`EXU_RFIDX_W-1:0] o_rf_wrdidx,
  output logic [`EXU_XLEN-1:0]    o_rf_wdata,
  output logic                    o_ret_valid,
  output logic [`EXU_RFIDX_W-1:0] o_ret_rdidx
);

  logic [`EXU_LANES-1:0]   res_valid;
  logic [`EXU_RFIDX_W-1:0] res_rdidx [`EXU_LANES];
  logic [`EXU_XLEN-1:0]    res_data  [`EXU_LANES];
  logic [`EXU_LANE_W-1:0]  wb_ptr;    // Follows the issue order
  logic                    wb_fire;

  for (genvar g = 0; g < `EXU_LANES; g++) begin : g_lane
    assign res_valid[g]       = lanes[g].res_valid;
    assign res_rdidx[g]       = lanes[g].res_rdidx;
    assign res_data[g]        = lanes[g].res_data;
    assign lanes[g].res_ready = i_wb_ready & (wb_ptr == g);
  end

  assign o_wb_valid = res_valid[wb_ptr];
  assign o_wb_rdidx = res_rdidx[wb_ptr];
  assign o_wb_data  = res_data[wb_ptr];
  assign wb_fire    = o_wb_valid & i_wb_ready;

  // Register file write and retire on the same handshake
  assign o_rf_wen    = wb_fire;
  assign o_rf_wrdidx = o_wb_rdidx;
  assign o_rf_wdata  = o_wb_data;
  assign o_ret_valid = wb_fire;
  assign o_ret_rdidx = o_wb_rdidx;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      wb_ptr <= '0;
    end else if (wb_fire) begin
      wb_ptr <= wb_ptr + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* verilog/exu_top.sv */
////////////////////////////////////////
// Execution stage top level
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module exu_top (
  input  logic                    clk,
  input  logic                    i_reset,
  input  logic                    i_valid,
  input  logic [31:0]             i_instr,
  input  logic                    i_wb_ready,
  output logic                    o_ready,
  output logic                    o_wb_valid,
  output logic [`EXU_RFIDX_W-1:0] o_wb_rdidx,
  output logic [`EXU_XLEN-1:0]    o_wb_data
);

  logic [`EXU_RFIDX_W-1:0] rf_rs1idx;
  logic [`EXU_RFIDX_W-1:0] rf_rs2idx;
  logic [`EXU_XLEN-1:0]    rf_rs1_data;
  logic [`EXU_XLEN-1:0]    rf_rs2_data;
  logic                    rf_wen;
  logic [`EXU_RFIDX_W-1:0] rf_wrdidx;
  logic [`EXU_XLEN-1:0]    rf_wdata;
  logic                    ret_valid;
  logic [`EXU_RFIDX_W-1:0] ret_rdidx;

  exu_lane_if u_lane_if [`EXU_LANES] ();

  exu_regfile u_regfile (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_rs1idx   (rf_rs1idx),
    .i_rs2idx   (rf_rs2idx),
    .i_wen      (rf_wen),
    .i_wrdidx   (rf_wrdidx),
    .i_wdata    (rf_wdata),
    .o_rs1_data (rf_rs1_data),
    .o_rs2_data (rf_rs2_data)
  );

  exu_dispatch u_dispatch (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_valid     (i_valid),
    .i_instr     (i_instr),
    .i_rs1_data  (rf_rs1_data),
    .i_rs2_data  (rf_rs2_data),
    .i_ret_valid (ret_valid),
    .i_ret_rdidx (ret_rdidx),
    .o_ready     (o_ready),
    .o_rs1idx    (rf_rs1idx),
    .o_rs2idx    (rf_rs2idx),
    .lanes       (u_lane_if)
  );

  // ALU lanes
  for (genvar g = 0; g < `EXU_LANES; g++) begin : g_lane
    exu_lane u_lane (
      .clk     (clk),
      .i_reset (i_reset),
      .port    (u_lane_if[g])
    );
  end

  exu_wbck u_wbck (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_wb_ready  (i_wb_ready),
    .lanes       (u_lane_if),
    .o_wb_valid  (o_wb_valid),
    .o_wb_rdidx  (o_wb_rdidx),
    .o_wb_data   (o_wb_data),
    .o_rf_wen    (rf_wen),
    .o_rf_wrdidx (rf_wrdidx),
    .o_rf_wdata  (rf_wdata),
    .o_ret_valid (ret_valid),
    .o_ret_rdidx (ret_rdidx)
  );

endmodule

`default_nettype wire

/* verification/exu_props.sv */
////////////////////////////////////////
// Write-back hold, latency and reset checks
// bound into the execution stage top
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module exu_props (
  input logic                    clk,
  input logic                    i_reset,
  input logic                    i_issue,
  input logic                    i_wb_valid,
  input logic                    i_wb_ready,
  input logic [`EXU_RFIDX_W-1:0] i_wb_rdidx,
  input logic [`EXU_XLEN-1:0]    i_wb_data
);

  int unsigned prop_errors = 0;   // Read by the testbench

  // Stalled result keeps valid and payload
  a_wb_hold: assert property (@(posedge clk) disable iff (i_reset)
    (i_wb_valid && !i_wb_ready) |=> (i_wb_valid && $stable(i_wb_rdidx) && $stable(i_wb_data)))
  else begin
    prop_errors++;
    $error("write-back result changed or dropped while stalled");
  end

  // Issue into an idle write-back port appears two edges later
  a_wb_latency: assert property (@(posedge clk) disable iff (i_reset)
    (i_issue && !i_wb_valid) ##1 i_wb_ready |=> i_wb_valid)
  else begin
    prop_errors++;
    $error("write-back did not appear two cycles after issue");
  end

  a_wb_rdidx: assert property (@(posedge clk) disable iff (i_reset)
    i_wb_valid |-> (i_wb_rdidx != '0))
  else begin
    prop_errors++;
    $error("write-back targets x0");
  end

  a_reset_idle: assert property (@(posedge clk) i_reset |=> !i_wb_valid)
  else begin
    prop_errors++;
    $error("write-back valid after reset");
  end

endmodule

bind exu_top exu_props u_props (
  .clk        (clk),
  .i_reset    (i_reset),
  .i_issue    (u_dispatch.issue_fire),
  .i_wb_valid (o_wb_valid),
  .i_wb_ready (i_wb_ready),
  .i_wb_rdidx (o_wb_rdidx),
  .i_wb_data  (o_wb_data)
);

`default_nettype wire

/* verification/exu_tb.sv */
////////////////////////////////////////
// Execution stage testbench with LFSR stimulus,
// a reference register model and write-back checks
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module exu_tb
  import exu_pkg::*;
();

  localparam int NUM_CHAIN   = 14;
  localparam int NUM_RANDOM  = 240;
  localparam int NUM_BP      = 40;
  localparam int CYCLE_LIMIT = 6 * (NUM_CHAIN + NUM_RANDOM + NUM_BP) + 100;
  localparam int MODE_CHAIN  = 0;
  localparam int MODE_RANDOM = 1;
  localparam int MODE_BP     = 2;
  // funct3 per kind with kind 0 in the low bits
  // Kinds 0..8 are ADD SUB AND OR XOR ADDI ANDI ORI XORI
  // 9 writes x0, 10 bad opcode, 11 bad funct3, 12 bad funct7
  localparam logic [26:0] KIND_F3 = {3'b100, 3'b110, 3'b111, 3'b000, 3'b100,
                                     3'b110, 3'b111, 3'b000, 3'b000};

  logic        clk;
  logic        i_reset;
  logic        i_valid;
  logic [31:0] i_instr;
  logic        i_wb_ready;
  logic        o_ready;
  logic        o_wb_valid;
  logic [`EXU_RFIDX_W-1:0] o_wb_rdidx;
  logic [`EXU_XLEN-1:0]    o_wb_data;

  logic [31:0] lfsr_state;
  logic [31:0] model_rf [16];
  logic [35:0] exp_q [$];       // {rd, data} in program order
  string       test_name;
  int          cycle_count = 0;
  int          wb_count = 0;
  int          mismatches = 0;
  int          other_errors = 0;
  int          prop_errors = 0;

  exu_top u_dut (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_valid    (i_valid),
    .i_instr    (i_instr),
    .i_wb_ready (i_wb_ready),
    .o_ready    (o_ready),
    .o_wb_valid (o_wb_valid),
    .o_wb_rdidx (o_wb_rdidx),
    .o_wb_data  (o_wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // Stimulus helpers

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] build_word(input int kind, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [11:0] imm);
    exu_instr_u w;
    w = '0;
    w.r.rd  = rd;
    w.r.rs1 = rs1;
    if (kind < 5 || kind == 9 || kind == 12) begin
      w.r.opcode = `EXU_OPC_OP;
      w.r.rs2    = rs2;
      w.r.funct3 = (kind < 5) ? KIND_F3[3*kind +: 3] : 3'b000;
      w.r.funct7 = (kind == 1) ? 7'b0100000 : (kind == 12) ? 7'b0000001 : 7'b0000000;
      if (kind == 9) begin
        w.r.rd = {rd[4], 4'b0000};   // Truncates to x0
      end
    end else begin
      w.i.opcode = (kind == 10) ? 7'b0000011 : `EXU_OPC_OPIMM;   // Load opcode is unsupported
      w.i.imm12  = imm;
      w.i.funct3 = (kind == 11) ? 3'b010 : (kind == 10) ? 3'b000 : KIND_F3[3*kind +: 3];
    end
    return w;
  endfunction

  // Reference model applied at accept in program order
  task automatic model_apply(input exu_instr_u w);
    logic [3:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        ok;
    rd  = w.r.rd[3:0];
    a   = model_rf[w.r.rs1[3:0]];
    b   = model_rf[w.r.rs2[3:0]];
    ok  = 1'b1;
    res = '0;
    if (w.i.opcode == `EXU_OPC_OPIMM) begin
      b = {{20{w.i.imm12[11]}}, w.i.imm12};
    end
    if (w.r.opcode == `EXU_OPC_OP && w.r.funct7 == 7'b0100000 && w.r.funct3 == 3'b000) begin
      res = a - b;
    end else if ((w.r.opcode == `EXU_OPC_OP && w.r.funct7 == 7'b0000000) ||
                 w.i.opcode == `EXU_OPC_OPIMM) begin
      case (w.r.funct3)
        3'b000:  res = a + b;
        3'b100:  res = a ^ b;
        3'b110:  res = a | b;
        3'b111:  res = a & b;
        default: ok = 1'b0;
      endcase
    end else begin
      ok = 1'b0;
    end
    if (ok && rd != 4'd0) begin
      model_rf[rd] = res;
      exp_q.push_back({rd, res});
    end
  endtask

  // Stall rules at the instruction port, before this cycle's write-back
  task automatic compare_ready(input exu_instr_u w);
    logic pending;
    pending = 1'b0;
    foreach (exp_q[k]) begin
      if (exp_q[k][35:32] == w.r.rs1[3:0] ||
          (w.r.opcode == `EXU_OPC_OP && exp_q[k][35:32] == w.r.rs2[3:0])) begin
        pending = 1'b1;
      end
    end
    assert (!(pending && o_ready)) else begin
      $display("Error in %s: instruction accepted while a source register is pending",
               test_name);
      other_errors++;
    end
    assert (exp_q.size() != 0 || o_ready) else begin
      $display("Error in %s: instruction stalled with nothing outstanding", test_name);
      other_errors++;
    end
  endtask

  // Called once per cycle after the inputs settle
  task automatic check_cycle(input logic accepted);
    logic [35:0] head;
    if (o_wb_valid && i_wb_ready) begin
      wb_count++;
      if (exp_q.size() == 0) begin
        $display("Error in %s: write-back to x%0d with nothing outstanding", test_name,
                 o_wb_rdidx);
        other_errors++;
      end else begin
        head = exp_q.pop_front();
        assert (o_wb_rdidx == head[35:32]) else begin
          $display("Mismatch in %s: rdidx expected %0d actual %0d", test_name, head[35:32],
                   o_wb_rdidx);
          mismatches++;
        end
        assert (o_wb_data == head[31:0]) else begin
          $display("Mismatch in %s: data expected %08h actual %08h", test_name, head[31:0],
                   o_wb_data);
          mismatches++;
        end
      end
    end
    if (accepted) begin
      model_apply(i_instr);
    end
  endtask

  task automatic send_word(input logic [31:0] word, input int mode);
    logic [31:0] r;
    logic        raised;
    logic        accepted;
    raised   = 1'b0;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      r = take_bits(3);
      case (mode)
        MODE_CHAIN:  i_wb_ready = 1'b1;
        MODE_RANDOM: i_wb_ready = (r[1:0] != 2'b00);
        default:     i_wb_ready = (r[2:0] == 3'b111);   // Heavy back-pressure
      endcase
      if (!raised) begin
        r = take_bits(2);
        raised = (mode != MODE_RANDOM) || (r[1:0] != 2'b00);   // Idle gaps
      end
      i_valid = raised;
      i_instr = word;
      #1;
      if (raised) begin
        compare_ready(i_instr);
      end
      accepted = raised && o_ready;
      check_cycle(accepted);
    end
  endtask

  ////////////////////////////////////////
  // Test phases

  task automatic chain_phase;
    send_word(build_word(5, 5'd1, 5'd5, 5'd0, 12'h123), MODE_CHAIN);   // x5 not yet written
    send_word(build_word(0, 5'd2, 5'd1, 5'd1, 12'h000), MODE_CHAIN);
    send_word(build_word(1, 5'd3, 5'd2, 5'd1, 12'h000), MODE_CHAIN);
    send_word(build_word(8, 5'd4, 5'd3, 5'd0, 12'hfff), MODE_CHAIN);
    send_word(build_word(2, 5'd5, 5'd4, 5'd2, 12'h000), MODE_CHAIN);
    send_word(build_word(3, 5'd6, 5'd5, 5'd3, 12'h000), MODE_CHAIN);
    send_word(build_word(4, 5'd7, 5'd6, 5'd1, 12'h000), MODE_CHAIN);
    send_word(build_word(7, 5'd8, 5'd7, 5'd0, 12'h800), MODE_CHAIN);
    send_word(build_word(6, 5'd9, 5'd8, 5'd0, 12'h7f0), MODE_CHAIN);
    send_word(build_word(0, 5'd0, 5'd9, 5'd9, 12'h000), MODE_CHAIN);   // Dropped
    send_word(build_word(0, 5'd10, 5'd0, 5'd9, 12'h000), MODE_CHAIN);
    send_word(build_word(10, 5'd11, 5'd10, 5'd0, 12'h000), MODE_CHAIN);
    send_word(build_word(5, 5'd12, 5'd10, 5'd0, 12'hfff), MODE_CHAIN);
    send_word(build_word(0, 5'd12, 5'd12, 5'd12, 12'h000), MODE_CHAIN);
  endtask

  task automatic random_phase(input int count, input int mode);
    logic [31:0] kind;
    logic [31:0] fld;
    for (int n = 0; n < count; n++) begin
      kind = take_bits(4);
      fld  = take_bits(27);
      send_word(build_word(int'(kind % 13), fld[26:22], fld[21:17], fld[16:12], fld[11:0]),
                mode);
    end
  endtask

  task automatic drain_phase;
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 32) begin
      @(negedge clk);
      i_valid    = 1'b0;
      i_wb_ready = 1'b1;
      #1;
      check_cycle(1'b0);
      n++;
    end
  endtask

  initial begin
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    i_reset    = 1'b1;
    i_valid    = 1'b0;
    i_instr    = '0;
    i_wb_ready = 1'b0;
    lfsr_state = 32'h012ac389;
    test_name  = "reset";
    for (int r = 0; r < 16; r++) begin
      model_rf[r] = '0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    i_reset = 1'b0;
    #1;
    assert (!o_wb_valid) else begin
      $display("Error in reset: o_wb_valid is high right after reset");
      other_errors++;
    end
    test_name = "chain";
    chain_phase();
    test_name = "random";
    random_phase(NUM_RANDOM, MODE_RANDOM);
    test_name = "backpressure";
    random_phase(NUM_BP, MODE_BP);
    test_name = "drain";
    drain_phase();
    assert (exp_q.size() == 0) else begin
      $display("Error in drain: %0d expected write-backs never arrived", exp_q.size());
      other_errors++;
    end
    prop_errors = u_dut.u_props.prop_errors;
    $display("Write-backs %0d, mismatches %0d, other errors %0d, assertion failures %0d",
             wb_count, mismatches, other_errors, prop_errors);
    if (mismatches + other_errors + prop_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+verilog
verilog/exu_pkg.sv
verilog/exu_lane_if.sv
verilog/exu_regfile.sv
verilog/exu_dispatch.sv
verilog/exu_lane.sv
verilog/exu_wbck.sv
verilog/exu_top.sv
verification/exu_props.sv
verification/exu_tb.sv

/* Bender.yml */
package:
  name: exu

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/exu_pkg.sv
      - verilog/exu_lane_if.sv
      - verilog/exu_regfile.sv
      - verilog/exu_dispatch.sv
      - verilog/exu_lane.sv
      - verilog/exu_wbck.sv
      - verilog/exu_top.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - verification/exu_props.sv
      - verification/exu_tb.sv
